// File: two_way_cache.f
+incdir+source
source/cache_pkg.sv
source/mem_pkg.sv
source/cache_ifs.sv
source/cache_way.sv
source/cache_ctrl.sv
source/data_memory.sv
source/two_way_cache.sv
sim/two_way_cache_sva.sv
sim/two_way_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the two-way cache testbench with Verilator and run it
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f two_way_cache.f \
        --top-module two_way_cache_tb -o two_way_cache_sim \
    && ./obj_dir/two_way_cache_sim \
    || exit 1

// File: sim/two_way_cache_tb.sv
// two_way_cache_tb: directed and seeded random traffic checked against a cache reference model

`include "cache_macros.svh"

module two_way_cache_tb import cache_pkg::*, mem_pkg::*; ();

    localparam int NUM_RANDOM   = 3000;
    localparam int NUM_DIRECTED = 64;   // upper bound on the directed accesses below
    localparam int NUM_OPS      = NUM_RANDOM + NUM_DIRECTED;
    localparam int CLK_PERIOD   = 10;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   req_valid_i;
    logic                   req_we_i;
    logic [`ADDR_WIDTH-1:0] req_addr_i;
    data_t                  req_wdata_i;
    logic                   rsp_valid_o;
    data_t                  rsp_rdata_o;
    logic                   rsp_hit_o;

    // reference model, unwritten words read as zero
    data_t gold_mem [logic [`ADDR_WIDTH-1:0]];
    tag_t  shadow_tag   [`NUM_SETS][2];
    logic  shadow_valid [`NUM_SETS][2];
    logic  shadow_lru   [`NUM_SETS];   // way to replace next

    two_way_cache dut_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_hit_o   (rsp_hit_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rdata(input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: rsp_rdata_o expected %h got %h", $time, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_hit(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: rsp_hit_o expected %b got %b", $time, expected, actual);
            abort_run();
        end
    endtask

    // eight tags spread over the tag field, four sets
    function automatic logic [`ADDR_WIDTH-1:0] pool_addr(input int idx);
        addr_u a;
        a.fields.tag = tag_t'((idx / `NUM_SETS) * 'h453);
        a.fields.set = set_t'(idx % `NUM_SETS);
        return a.word;
    endfunction

    // way holding the address, or -1 on a miss
    function automatic int find_way(input addr_u a);
        for (int w = 0; w < 2; w++) begin
            if (shadow_valid[a.fields.set][w] && shadow_tag[a.fields.set][w] == a.fields.tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic update_shadow(input addr_u a, input int way);
        set_t s;
        int   victim;
        s = a.fields.set;
        if (way >= 0) begin
            shadow_lru[s] = (way == 0);     // other way becomes lru
        end else begin
            victim = shadow_lru[s] ? 1 : 0;
            shadow_tag[s][victim]   = a.fields.tag;
            shadow_valid[s][victim] = 1'b1;
            shadow_lru[s]           = (victim == 0);
        end
    endtask

    // one request, wait for its response, compare with the model
    task automatic run_access(input logic we, input logic [`ADDR_WIDTH-1:0] addr,
                              input data_t wdata);
        addr_u a;
        int    way;
        logic  exp_hit;
        data_t exp_data;
        int    lat;
        a.word  = addr;
        way     = find_way(a);
        exp_hit = (way >= 0);
        if (we) begin
            exp_data       = wdata;
            gold_mem[addr] = wdata;
        end else begin
            exp_data = gold_mem.exists(addr) ? gold_mem[addr] : '0;
        end
        update_shadow(a, way);
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b1;
        req_we_i    = we;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        lat = 1;
        while (rsp_valid_o !== 1'b1) begin
            @(posedge clk_i);
            #1;
            lat++;
        end
        check_hit(exp_hit, rsp_hit_o);
        check_rdata(exp_data, rsp_rdata_o);
        if (exp_hit && lat != 1) begin
            $display("hit response for address %h came %0d cycles after its request, not 1",
                     addr, lat);
            abort_run();
        end
    endtask

    initial begin
        #((NUM_OPS * (3 + 2 * `MEM_LATENCY) * CLK_PERIOD * 2) + 16 * CLK_PERIOD);
        $display("timeout: the cache did not finish %0d accesses in the time allowed", NUM_OPS);
        abort_run();
    end

    initial begin
        int    idx;
        logic  we;
        data_t wval;
        void'($urandom(32'hbce53d76));
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        for (int s = 0; s < `NUM_SETS; s++) begin
            shadow_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                shadow_valid[s][w] = 1'b0;
                shadow_tag[s][w]   = '0;
            end
        end
        repeat (16) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        if (rsp_valid_o !== 1'b0) begin
            $display("rsp_valid_o is not low after reset");
            abort_run();
        end

        // cold sweep, every first touch misses
        for (int i = 0; i < 32; i++) begin
            run_access(1'b0, pool_addr(i), '0);
        end

        // read back right after a write
        run_access(1'b1, pool_addr(5), $urandom());
        run_access(1'b0, pool_addr(5), '0);
        run_access(1'b1, pool_addr(6), $urandom());
        run_access(1'b0, pool_addr(6), '0);

        // lru alternation in set 1
        run_access(1'b0, pool_addr(1), '0);
        run_access(1'b0, pool_addr(5), '0);
        run_access(1'b0, pool_addr(1), '0);
        run_access(1'b0, pool_addr(9), '0);
        run_access(1'b0, pool_addr(1), '0);
        run_access(1'b0, pool_addr(5), '0);
        run_access(1'b0, pool_addr(9), '0);

        // dirty line pushed out by two other tags of set 2
        run_access(1'b1, pool_addr(2), $urandom());
        run_access(1'b0, pool_addr(6), '0);
        run_access(1'b0, pool_addr(10), '0);
        run_access(1'b0, pool_addr(2), '0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            idx  = int'($urandom_range(31, 0));
            we   = 1'($urandom_range(1, 0));
            wval = $urandom();
            run_access(we, pool_addr(idx), wval);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: sim/two_way_cache_sva.sv
// two_way_cache_sva: protocol and timing checks bound onto the cache controller

module two_way_cache_sva import cache_pkg::*; (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        req_valid_i,
    input logic        rsp_valid_i,
    input logic        any_hit_i,
    input logic        cmd_valid_i,
    input ctrl_state_e state_i
);

    // requester holds off until the response strobe
    property no_req_while_busy;
        @(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |-> (state_i == IDLE);
    endproperty

    property hit_responds_next_cycle;
        @(posedge clk_i) disable iff (!rst_n_i)
        (state_i == IDLE && req_valid_i && any_hit_i) |=> rsp_valid_i;
    endproperty

    property rsp_single_cycle;
        @(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |=> !rsp_valid_i;
    endproperty

    // memory traffic only belongs to a miss
    property mem_cmd_in_miss_states;
        @(posedge clk_i) disable iff (!rst_n_i)
        cmd_valid_i |-> (state_i == WRITEBACK || state_i == FILL);
    endproperty

    assert property (no_req_while_busy)
        else $error("request strobe while the controller is busy");
    assert property (hit_responds_next_cycle)
        else $error("hit request without a response on the next cycle");
    assert property (rsp_single_cycle)
        else $error("response strobe held longer than one cycle");
    assert property (mem_cmd_in_miss_states)
        else $error("memory command outside write-back or fill");

endmodule

bind cache_ctrl two_way_cache_sva sva_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .rsp_valid_i (rsp_valid_o),
    .any_hit_i   (any_hit),
    .cmd_valid_i (cmd_valid_q),
    .state_i     (state_q)
);

// File: source/two_way_cache.sv
// two_way_cache: two-way set-associative write-back cache with its backing memory

`include "cache_macros.svh"

module two_way_cache import cache_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  logic                   req_we_i,
    input  logic [`ADDR_WIDTH-1:0] req_addr_i,
    input  logic [`DATA_WIDTH-1:0] req_wdata_i,
    output logic                   rsp_valid_o,
    output logic [`DATA_WIDTH-1:0] rsp_rdata_o,
    output logic                   rsp_hit_o
);

    addr_u req_addr;

    way_if way0_bus ();
    way_if way1_bus ();
    mem_if mem_bus ();

    assign req_addr = addr_u'(req_addr_i);

    cache_way way0_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .port    (way0_bus.way)
    );

    cache_way way1_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .port    (way1_bus.way)
    );

    cache_ctrl ctrl_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_hit_o   (rsp_hit_o),
        .way0        (way0_bus.ctrl),
        .way1        (way1_bus.ctrl),
        .mem         (mem_bus.ctrl)
    );

    data_memory mem_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .port    (mem_bus.mem)
    );

endmodule

// File: source/data_memory.sv
// data_memory: word-addressed backing store answering each command after a fixed latency

`include "cache_macros.svh"

module data_memory import mem_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    mem_if.mem   port
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    data_t mem_q [1 << `ADDR_WIDTH];

    logic [CNT_W-1:0] cnt_q;    // cycles left until done
    logic             done_q;
    data_t            rdata_q;

    initial begin
        for (int i = 0; i < (1 << `ADDR_WIDTH); i++) begin
            mem_q[i] = '0;
        end
    end

    // writes land at acceptance, reads are captured then and held until done
    always @(posedge clk_i) begin
        if (port.cmd_valid) begin
            if (port.cmd == MEM_WRITE) begin
                mem_q[port.addr.word] <= port.wdata;
            end else begin
                rdata_q <= mem_q[port.addr.word];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (port.cmd_valid) begin
            cnt_q  <= CNT_W'(`MEM_LATENCY - 1);
            done_q <= 1'b0;
        end else if (cnt_q != '0) begin
            cnt_q  <= cnt_q - 1'b1;
            done_q <= (cnt_q == CNT_W'(1));  // done on the last count
        end else begin
            done_q <= 1'b0;
        end
    end

    assign port.done  = done_q;
    assign port.rdata = rdata_q;

endmodule

// File: source/cache_ctrl.sv
// cache_ctrl combines way hits, keeps per-set lru and runs the miss, write-back and fill FSM

`include "cache_macros.svh"

module cache_ctrl import cache_pkg::*, mem_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  req_valid_i,
    input  logic  req_we_i,
    input  addr_u req_addr_i,
    input  data_t req_wdata_i,
    output logic  rsp_valid_o,
    output data_t rsp_rdata_o,
    output logic  rsp_hit_o,
    way_if.ctrl   way0,
    way_if.ctrl   way1,
    mem_if.ctrl   mem
);

    ctrl_state_e state_q;
    logic [`NUM_SETS-1:0] lru_q;            // names the way to evict next
    logic [$clog2(`NUM_WAYS)-1:0] victim_q;

    // latched request
    addr_u req_q;
    logic  req_we_q;
    data_t req_wdata_q;

    logic     cmd_valid_q;
    mem_cmd_e mem_cmd_q;
    addr_u    mem_addr_q;
    data_t    mem_wdata_q;

    data_t rsp_rdata_q;
    logic  rsp_hit_q;

    addr_u       cur_addr;
    logic        any_hit;
    data_t       hit_data;
    logic        victim_sel;
    line_state_t victim_state;
    data_t       victim_data;
    logic        victim_dirty;
    addr_u       wb_addr;
    logic        wr_hit;
    logic        fill_done;
    data_t       fill_data;
    line_state_t new_state;

    // live request in IDLE and the latched one during a miss
    assign cur_addr = (state_q == IDLE) ? req_addr_i : req_q;

    assign way0.lookup_set = cur_addr.fields.set;
    assign way0.lookup_tag = cur_addr.fields.tag;
    assign way1.lookup_set = cur_addr.fields.set;
    assign way1.lookup_tag = cur_addr.fields.tag;

    assign any_hit  = way0.hit | way1.hit;
    assign hit_data = way1.hit ? way1.rd_data : way0.rd_data;

    assign victim_sel   = lru_q[cur_addr.fields.set];
    assign victim_state = victim_sel ? way1.rd_state : way0.rd_state;
    assign victim_data  = victim_sel ? way1.rd_data : way0.rd_data;
    assign victim_dirty = victim_state.valid && victim_state.dirty;

    always_comb begin
        wb_addr.fields.tag = victim_sel ? way1.rd_tag : way0.rd_tag;
        wb_addr.fields.set = cur_addr.fields.set;
    end

    assign wr_hit    = (state_q == IDLE) && req_valid_i && req_we_i && any_hit;
    assign fill_done = (state_q == FILL) && mem.done;
    assign fill_data = req_we_q ? req_wdata_q : mem.rdata;

    always_comb begin
        new_state.valid = 1'b1;
        new_state.dirty = fill_done ? req_we_q : 1'b1;  // write hit always dirties
    end

    // write strobe goes to the hit way or to the victim at the end of a fill
    assign way0.wr_en = (wr_hit && !way1.hit) || (fill_done && victim_q == 1'b0);
    assign way1.wr_en = (wr_hit && way1.hit) || (fill_done && victim_q == 1'b1);

    assign way0.wr_set   = cur_addr.fields.set;
    assign way0.wr_tag   = cur_addr.fields.tag;
    assign way0.wr_data  = fill_done ? fill_data : req_wdata_i;
    assign way0.wr_state = new_state;
    assign way1.wr_set   = cur_addr.fields.set;
    assign way1.wr_tag   = cur_addr.fields.tag;
    assign way1.wr_data  = fill_done ? fill_data : req_wdata_i;
    assign way1.wr_state = new_state;

    assign mem.cmd_valid = cmd_valid_q;
    assign mem.cmd       = mem_cmd_q;
    assign mem.addr      = mem_addr_q;
    assign mem.wdata     = mem_wdata_q;

    assign rsp_valid_o = (state_q == RESPOND);
    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_hit_o   = rsp_hit_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            lru_q       <= '0;
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (req_valid_i) begin
                        if (any_hit) begin
                            lru_q[cur_addr.fields.set] <= ~way1.hit; // other way is lru
                            state_q <= RESPOND;
                        end else begin
                            state_q     <= victim_dirty ? WRITEBACK : FILL;
                            cmd_valid_q <= 1'b1;
                        end
                    end
                end
                WRITEBACK: begin
                    if (mem.done) begin
                        state_q     <= FILL;
                        cmd_valid_q <= 1'b1;    // fetch follows the write-back
                    end
                end
                FILL: begin
                    if (mem.done) begin
                        lru_q[req_q.fields.set] <= ~victim_q;
                        state_q <= RESPOND;
                    end
                end
                default: state_q <= IDLE;       // RESPOND lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    req_q       <= req_addr_i;
                    req_we_q    <= req_we_i;
                    req_wdata_q <= req_wdata_i;
                    victim_q    <= victim_sel;
                    rsp_hit_q   <= any_hit;
                    rsp_rdata_q <= req_we_i ? req_wdata_i : hit_data;
                    mem_cmd_q   <= victim_dirty ? MEM_WRITE : MEM_READ;
                    mem_addr_q  <= victim_dirty ? wb_addr : req_addr_i;
                    mem_wdata_q <= victim_data;
                end
            end
            WRITEBACK: begin
                if (mem.done) begin
                    mem_cmd_q  <= MEM_READ;
                    mem_addr_q <= req_q;
                end
            end
            FILL: begin
                if (mem.done) begin
                    rsp_rdata_q <= fill_data;   // write data on a write miss
                end
            end
            default: ;
        endcase
    end

endmodule

// File: source/cache_way.sv
// cache_way holds data, tag and state for one way across all sets and compares tags

`include "cache_macros.svh"

module cache_way import cache_pkg::*, mem_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    way_if.way   port
);

    data_t       data_q  [`NUM_SETS];
    tag_t        tag_q   [`NUM_SETS];
    line_state_t state_q [`NUM_SETS];

    line_state_t entry_state;
    tag_t        entry_tag;

    assign entry_state = state_q[port.lookup_set];
    assign entry_tag   = tag_q[port.lookup_set];

    // zero-latency lookup
    assign port.hit      = entry_state.valid && (entry_tag == port.lookup_tag);
    assign port.rd_data  = data_q[port.lookup_set];
    assign port.rd_tag   = entry_tag;
    assign port.rd_state = entry_state;

    // valid and dirty bits cleared on reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_SETS; i++) begin
                state_q[i] <= '0;
            end
        end else if (port.wr_en) begin
            state_q[port.wr_set] <= port.wr_state;
        end
    end

    // line payload
    always_ff @(posedge clk_i) begin
        if (port.wr_en) begin
            data_q[port.wr_set] <= port.wr_data;
            tag_q[port.wr_set]  <= port.wr_tag;
        end
    end

endmodule

// File: source/cache_ifs.sv
// cache interfaces: controller to way lookup/write, controller to backing memory

interface way_if import cache_pkg::*, mem_pkg::*; ();

    // lookup side, driven by the controller
    set_t        lookup_set;
    tag_t        lookup_tag;

    // write side, wr_en is a one-cycle strobe
    logic        wr_en;
    set_t        wr_set;
    tag_t        wr_tag;
    data_t       wr_data;
    line_state_t wr_state;

    // answers from the way, combinational
    logic        hit;
    data_t       rd_data;
    line_state_t rd_state;   // entry at lookup_set, victim candidate
    tag_t        rd_tag;

    modport ctrl (
        output lookup_set, lookup_tag,
        output wr_en, wr_set, wr_tag, wr_data, wr_state,
        input  hit, rd_data, rd_state, rd_tag
    );

    modport way (
        input  lookup_set, lookup_tag,
        input  wr_en, wr_set, wr_tag, wr_data, wr_state,
        output hit, rd_data, rd_state, rd_tag
    );

endinterface

interface mem_if import cache_pkg::*, mem_pkg::*; ();

    logic     cmd_valid;    // one-cycle strobe, one command in flight
    mem_cmd_e cmd;
    addr_u    addr;
    data_t    wdata;
    data_t    rdata;        // valid with done on reads
    logic     done;

    modport ctrl (
        output cmd_valid, cmd, addr, wdata,
        input  rdata, done
    );

    modport mem (
        input  cmd_valid, cmd, addr, wdata,
        output rdata, done
    );

endinterface

// File: source/mem_pkg.sv
// mem_pkg: memory-side types, the data word and the memory command

`include "cache_macros.svh"

package mem_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_cmd_e;

endpackage

// File: source/cache_pkg.sv
// cache_pkg: cache-side types for address decode, line state and controller state

`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`TAG_BITS-1:0] tag_t;
    typedef logic [`SET_BITS-1:0] set_t;

    // tag sits above the set index
    typedef struct packed {
        tag_t tag;
        set_t set;
    } addr_fields_t;

    // ways decode tag and set, memory sees a flat word index
    typedef union packed {
        addr_fields_t            fields;
        logic [`ADDR_WIDTH-1:0]  word;
    } addr_u;

    typedef struct packed {
        logic valid;
        logic dirty;    // line differs from memory
    } line_state_t;

    typedef enum logic [1:0] {
        IDLE,       // waiting for a request
        RESPOND,    // one-cycle response strobe
        WRITEBACK,  // dirty victim going out
        FILL        // new word coming in
    } ctrl_state_e;

endpackage

// File: source/cache_macros.svh
// cache_macros: widths, set count and memory latency for the two-way cache

`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// word address into the backing memory
`define ADDR_WIDTH 16

// one data word per line
`define DATA_WIDTH 32

// four sets
`define SET_BITS 2
`define NUM_SETS (1 << `SET_BITS)

// everything above the set index is tag
`define TAG_BITS (`ADDR_WIDTH - `SET_BITS)

// fixed two-way organisation, one lru bit per set covers it
`define NUM_WAYS 2

// cycles from a memory command to its done strobe
`define MEM_LATENCY 3

`endif
